/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_lookup.sv
      - verilog/dcache_set_store.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: test
    files:
      - tb/dcache_mem_model.sv
      - tb/dcache_tb.sv

/* all.f */
verilog/dcache_pkg.sv
verilog/dcache_lookup.sv
verilog/dcache_set_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

/* tb/dcache_mem_model.sv */
`timescale 1ns/100ps

module dcache_mem_model
	import dcache_pkg::*;
(
	input  logic     CLK,
	input  logic     nRST,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	// Sparse word store, untouched words read back the fill pattern
	word_t       mem [logic [29:0]];
	logic [1:0]  wait_cnt;
	logic [29:0] word_addr;
	word_t       load_q;
	int          write_count;

	assign word_addr = {mem_req.addr.tag, mem_req.addr.idx, mem_req.addr.blkoff};

	// Pattern mixes every address bit
	function automatic word_t initial_word(input logic [29:0] wa);
		return (32'(wa) * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
	endfunction

	function automatic word_t peek(input logic [29:0] wa);
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return initial_word(wa);
	endfunction

	// Two busy cycles, word moves in the third
	assign mem_rsp.busy = (mem_req.ren || mem_req.wen) && (wait_cnt != 2'd2);
	assign mem_rsp.load = load_q;

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= '0;
			load_q <= '0;
			write_count <= 0;
		end else begin
			// Address is steady for the whole transfer
			load_q <= peek(word_addr);
			if (mem_req.ren || mem_req.wen) begin
				if (wait_cnt == 2'd2) begin
					wait_cnt <= '0;
					if (mem_req.wen) begin
						mem[word_addr] = mem_req.store;
						write_count <= write_count + 1;
					end
				end else begin
					wait_cnt <= wait_cnt + 2'd1;
				end
			end else begin
				wait_cnt <= '0;
			end
		end
	end

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
	import dcache_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int DIRECTED_OPS = 12;
	localparam int RANDOM_OPS   = 64;
	// Worst access is a dirty miss plus issue and drop cycles
	localparam int OP_CYCLES    = 16;
	// Every line dirty, DCHK plus two three-cycle words each
	localparam int FLUSH_CYCLES = NUM_SETS * NUM_WAYS * 8 + 20;
	localparam int WATCHDOG_NS  =
		((DIRECTED_OPS + RANDOM_OPS) * OP_CYCLES + FLUSH_CYCLES + RESET_CYCLES) * 100;
	localparam logic [TAG_W-1:0] TAG_BASE = 26'h00A_BC0;

	logic      CLK;
	logic      nRST;
	proc_req_t req;
	proc_rsp_t rsp;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp;

	integer seed;
	int     error_count;
	int     check_count;
	word_t  exp_load;

	// Reference cache state and shadow memory
	logic             ref_valid [NUM_SETS][NUM_WAYS];
	logic             ref_dirty [NUM_SETS][NUM_WAYS];
	logic [TAG_W-1:0] ref_tag [NUM_SETS][NUM_WAYS];
	word_t            ref_data [NUM_SETS][NUM_WAYS][2];
	logic             ref_lru [NUM_SETS];
	word_t            shadow [logic [29:0]];

	// Expected and observed word transfers, plus every word address used
	mem_req_t    exp_xfer[$];
	mem_req_t    got_xfer[$];
	logic [29:0] touched[$];

	dcache_top uut (
		.CLK     (CLK),
		.nRST    (nRST),
		.req     (req),
		.rsp     (rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	dcache_mem_model u_mem (
		.CLK     (CLK),
		.nRST    (nRST),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	always #50 CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Same address mix as the memory's fill
	function automatic word_t expected_fill(input logic [29:0] wa);
		return (32'(wa) * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
	endfunction

	function automatic word_t shadow_read(input logic [29:0] wa);
		if (shadow.exists(wa)) begin
			return shadow[wa];
		end
		return expected_fill(wa);
	endfunction

	// Write one whole line back, word 0 first
	function automatic void push_writeback(input int s, input int w);
		mem_req_t x;
		for (int k = 0; k < 2; k++) begin
			x = '0;
			x.wen = 1'b1;
			x.addr = {ref_tag[s][w], IDX_W'(s), 1'(k), 2'b00};
			x.store = ref_data[s][w][k];
			exp_xfer.push_back(x);
			shadow[{ref_tag[s][w], IDX_W'(s), 1'(k)}] = x.store;
		end
	endfunction

	// One access on the 2-way LRU write-back cache, returns the word it sees
	function automatic word_t ref_access(input logic wr, input dcache_addr_t a, input word_t d);
		int       way;
		int       v;
		mem_req_t x;
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[a.idx][w] && ref_tag[a.idx][w] == a.tag) begin
				way = w;
			end
		end
		if (way < 0) begin
			// Miss replaces the LRU way, dirty victim goes out first
			v = ref_lru[a.idx];
			if (ref_valid[a.idx][v] && ref_dirty[a.idx][v]) begin
				push_writeback(a.idx, v);
			end
			for (int k = 0; k < 2; k++) begin
				x = '0;
				x.ren = 1'b1;
				x.addr = {a.tag, a.idx, 1'(k), 2'b00};
				exp_xfer.push_back(x);
				ref_data[a.idx][v][k] = shadow_read({a.tag, a.idx, 1'(k)});
			end
			ref_valid[a.idx][v] = 1'b1;
			ref_dirty[a.idx][v] = 1'b0;
			ref_tag[a.idx][v] = a.tag;
			way = v;
		end
		// Hit makes the other way LRU
		ref_lru[a.idx] = (way == 0);
		if (wr) begin
			ref_data[a.idx][way][a.blkoff] = d;
			ref_dirty[a.idx][way] = 1'b1;
		end
		return ref_data[a.idx][way][a.blkoff];
	endfunction

	// Flush order is set by set, way 0 before way 1
	function automatic void ref_flush();
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (ref_dirty[s][w]) begin
					push_writeback(s, w);
					ref_dirty[s][w] = 1'b0;
				end
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t exp, input word_t got);
		check_count++;
		if (exp !== got) begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, got);
		end
	endtask

	// Store word only matters on a write
	task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t got);
		check_count++;
		if (exp.ren !== got.ren || exp.wen !== got.wen || exp.addr !== got.addr ||
			(exp.wen && exp.store !== got.store)) begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic compare_xfers();
		mem_req_t e;
		mem_req_t g;
		if (exp_xfer.size() != got_xfer.size()) begin
			error_count++;
			$display("Wrong number of memory transfers at %0t: expected %0d, saw %0d",
				$time, exp_xfer.size(), got_xfer.size());
		end
		while (exp_xfer.size() > 0 && got_xfer.size() > 0) begin
			e = exp_xfer.pop_front();
			g = got_xfer.pop_front();
			check_mem("mem_req", e, g);
		end
		exp_xfer.delete();
		got_xfer.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor and checker
	////////////////////////////////////////////////////////////////////////////

	// A word moves in the cycle busy is low
	always @(posedge CLK) begin
		if (nRST && (mem_req.ren || mem_req.wen) && !mem_rsp.busy) begin
			got_xfer.push_back(mem_req);
		end
	end

	// Hit cycle closes an access
	always @(posedge CLK) begin
		if (nRST && rsp.hit) begin
			if (req.ren) begin
				check_word("rsp.load", exp_load, rsp.load);
			end
			compare_xfers();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the cache stopped answering", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic dcache_addr_t make_addr(input int tsel, input int idx, input logic blk);
		dcache_addr_t a;
		a = '0;
		a.tag = TAG_BASE + TAG_W'(tsel);
		a.idx = IDX_W'(idx);
		a.blkoff = blk;
		return a;
	endfunction

	// Called on a rising edge, returns one edge after hit
	task automatic run_access(input logic wr, input dcache_addr_t a, input word_t d);
		word_t exp;
		exp = ref_access(wr, a, d);
		touched.push_back({a.tag, a.idx, 1'b0});
		touched.push_back({a.tag, a.idx, 1'b1});
		exp_load <= exp;
		req.ren <= !wr;
		req.wen <= wr;
		req.addr <= a;
		req.store <= d;
		do begin
			@(posedge CLK);
		end while (!rsp.hit);
		req.ren <= 1'b0;
		req.wen <= 1'b0;
		@(posedge CLK);
	endtask

	initial begin
		logic [31:0] r;
		CLK = 1'b0;
		nRST = 1'b0;
		req = '0;
		seed = 21;
		error_count = 0;
		check_count = 0;
		exp_load = '0;
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
				ref_tag[s][w] = '0;
				ref_data[s][w][0] = '0;
				ref_data[s][w][1] = '0;
			end
		end

		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(posedge CLK);
		@(posedge CLK);
		if (rsp.hit || rsp.flushed || mem_req.ren || mem_req.wen) begin
			error_count++;
			$display("Outputs not idle after reset");
		end

		// Cold read, then write and read back, other word untouched
		run_access(1'b0, make_addr(0, 1, 1'b0), '0);
		run_access(1'b1, make_addr(0, 1, 1'b0), 32'hDEAD_BEEF);
		run_access(1'b0, make_addr(0, 1, 1'b0), '0);
		run_access(1'b0, make_addr(0, 1, 1'b1), '0);

		// Third tag in set 5 pushes out the written line
		run_access(1'b1, make_addr(0, 5, 1'b0), 32'h1357_9BDF);
		run_access(1'b0, make_addr(1, 5, 1'b0), '0);
		run_access(1'b0, make_addr(2, 5, 1'b1), '0);

		// A, B, A, C in set 2 evicts B, then A still hits
		run_access(1'b0, make_addr(0, 2, 1'b0), '0);
		run_access(1'b0, make_addr(1, 2, 1'b0), '0);
		run_access(1'b0, make_addr(0, 2, 1'b1), '0);
		run_access(1'b0, make_addr(2, 2, 1'b0), '0);
		run_access(1'b0, make_addr(0, 2, 1'b0), '0);

		// Four tags keep the sets in conflict
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = $random(seed);
			run_access(r[6], make_addr(int'(r[1:0]), int'(r[4:2]), r[5]), $random(seed));
		end

		// Halt writes back every dirty line
		ref_flush();
		req.halt <= 1'b1;
		do begin
			@(posedge CLK);
		end while (!rsp.flushed);
		compare_xfers();
		repeat (4) begin
			@(posedge CLK);
			if (!rsp.flushed) begin
				error_count++;
				$display("Flushed dropped at %0t while halt was held", $time);
			end
		end

		// Memory must hold what the shadow holds
		foreach (touched[i]) begin
			check_word("memory", shadow_read(touched[i]), u_mem.peek(touched[i]));
		end

		$display("Checks: %0d, errors: %0d, memory writes: %0d",
			check_count, error_count, u_mem.write_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,
	input  proc_req_t  req,
	input  lookup_t    look,
	input  mem_rsp_t   mem_rsp,
	output proc_rsp_t  rsp,
	output mem_req_t   mem_req,
	output store_cmd_t cmd
);

	cache_state_t     state;
	cache_state_t     next_state;
	logic             access;
	// Word 0 or word 1 of the line in flight
	logic             word_sel;
	// Line and set that a write-back comes from
	line_t            src_line;
	logic [IDX_W-1:0] src_idx;

	assign access = req.ren || req.wen;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt wins over a pending miss
				if (req.halt) begin
					next_state = DCHK;
				end else if (access && !look.hit) begin
					if (look.victim.valid && look.victim.dirty) begin
						next_state = WB1;
					end else begin
						next_state = FD1;
					end
				end
			end
			// Memory states advance once busy drops
			WB1:  next_state = mem_rsp.busy ? WB1 : WB2;
			WB2:  next_state = mem_rsp.busy ? WB2 : FD1;
			FD1:  next_state = mem_rsp.busy ? FD1 : FD2;
			FD2:  next_state = mem_rsp.busy ? FD2 : IDLE;
			DCHK: next_state = look.dirty_any ? WBD1 : FLUSHED;
			WBD1: next_state = mem_rsp.busy ? WBD1 : WBD2;
			WBD2: next_state = mem_rsp.busy ? WBD2 : DCHK;
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rsp.hit = 1'b0;
		rsp.flushed = 1'b0;
		rsp.load = look.load;
		mem_req.ren = 1'b0;
		mem_req.wen = 1'b0;
		cmd.op = SOP_NONE;
		word_sel = 1'b0;
		// Miss write-back uses the victim by default
		src_line = look.victim;
		src_idx = req.addr.idx;

		case (state)
			IDLE: begin
				if (!req.halt && access && look.hit) begin
					rsp.hit = 1'b1;
					cmd.op = req.wen ? SOP_WRITE_HIT : SOP_TOUCH;
				end
			end
			WB1, WB2: begin
				mem_req.wen = 1'b1;
				word_sel = (state == WB2);
			end
			FD1, FD2: begin
				mem_req.ren = 1'b1;
				word_sel = (state == FD2);
				// Fetched word goes into the array as it arrives
				if (!mem_rsp.busy) begin
					cmd.op = (state == FD2) ? SOP_FILL1 : SOP_FILL0;
				end
			end
			WBD1, WBD2: begin
				mem_req.wen = 1'b1;
				word_sel = (state == WBD2);
				src_line = look.dirty_line;
				src_idx = look.dirty_idx;
				if ((state == WBD2) && !mem_rsp.busy) begin
					cmd.op = SOP_CLEAN;
				end
			end
			FLUSHED: begin
				rsp.flushed = 1'b1;
			end
			default: begin
			end
		endcase

		// Writes go to the source line address, reads to the requested one
		mem_req.addr.tag = mem_req.wen ? src_line.tag : req.addr.tag;
		mem_req.addr.idx = mem_req.wen ? src_idx : req.addr.idx;
		mem_req.addr.blkoff = word_sel;
		mem_req.addr.byteoff = 2'b00;
		mem_req.store = word_sel ? src_line.word1 : src_line.word0;
	end

	// One memory transfer direction at a time
	a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen));

endmodule

/* verilog/dcache_lookup.sv */
`timescale 1ns/100ps

module dcache_lookup
	import dcache_pkg::*;
(
	input  line_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines,
	input  logic [NUM_SETS-1:0]                lru,
	input  dcache_addr_t                       addr,
	output lookup_t                            result
);

	// Both ways of the addressed set
	line_t [NUM_WAYS-1:0] set_lines;
	logic [NUM_WAYS-1:0]  match;
	line_t                hit_line;

	assign set_lines = lines[addr.idx];

	// Tag compare, only valid ways count
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			match[w] = set_lines[w].valid && (set_lines[w].tag == addr.tag);
		end
	end

	// Way 1 wins only when it matches, otherwise way 0
	assign hit_line = set_lines[match[1]];

	always_comb begin
		result = '0;
		result.hit = |match;
		result.hit_way = match[1];

		// Word picked by block offset
		result.load = addr.blkoff ? hit_line.word1 : hit_line.word0;

		// LRU bit points at the way to replace
		result.victim = set_lines[lru[addr.idx]];

		// First dirty line, set order, way 0 before way 1
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!result.dirty_any && lines[s][w].dirty) begin
					result.dirty_any = 1'b1;
					result.dirty_idx = IDX_W'(s);
					result.dirty_way = 1'(w);
					result.dirty_line = lines[s][w];
				end
			end
		end
	end

	// Fills only go to the LRU way after a miss, so one tag lives in one way
	a_single_hit: assert final (!(match[0] && match[1]));

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////////////////////

	// 26 bit tag, 3 bit set index, one word select bit, 2 byte bits
	localparam int TAG_W    = 26;
	localparam int IDX_W    = 3;
	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 2;

	typedef logic [31:0] word_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blkoff;
		logic [1:0]       byteoff;
	} dcache_addr_t;

	// One way of one set
	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		word_t            word0;
		word_t            word1;
	} line_t;

	////////////////////////////////////////////////////////////////////////////
	// Ports
	////////////////////////////////////////////////////////////////////////////

	// Processor side, held until hit or flushed
	typedef struct packed {
		logic         ren;
		logic         wen;
		logic         halt;
		dcache_addr_t addr;
		word_t        store;
	} proc_req_t;

	typedef struct packed {
		logic  hit;
		logic  flushed;
		word_t load;
	} proc_rsp_t;

	// Memory side, one word per transfer
	typedef struct packed {
		logic         ren;
		logic         wen;
		dcache_addr_t addr;
		word_t        store;
	} mem_req_t;

	typedef struct packed {
		logic  busy;
		word_t load;
	} mem_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// Internal paths
	////////////////////////////////////////////////////////////////////////////

	// Tag compare result plus victim and first dirty line
	typedef struct packed {
		logic             hit;
		logic             hit_way;
		word_t            load;
		line_t            victim;
		logic             dirty_any;
		logic [IDX_W-1:0] dirty_idx;
		logic             dirty_way;
		line_t            dirty_line;
	} lookup_t;

	typedef enum logic [2:0] {
		SOP_NONE      = 3'd0,
		SOP_WRITE_HIT = 3'd1,
		SOP_TOUCH     = 3'd2,
		SOP_FILL0     = 3'd3,
		SOP_FILL1     = 3'd4,
		SOP_CLEAN     = 3'd5
	} store_op_t;

	typedef struct packed {
		store_op_t op;
	} store_cmd_t;

	typedef enum logic [3:0] {
		IDLE    = 4'd1,
		WB1     = 4'd2,
		WB2     = 4'd3,
		FD1     = 4'd4,
		FD2     = 4'd5,
		WBD1    = 4'd6,
		WBD2    = 4'd7,
		DCHK    = 4'd8,
		FLUSHED = 4'd13
	} cache_state_t;

endpackage

/* verilog/dcache_set_store.sv */
`timescale 1ns/100ps

module dcache_set_store
	import dcache_pkg::*;
(
	input  logic                               CLK,
	input  logic                               nRST,
	input  dcache_addr_t                       addr,
	input  word_t                              store,
	input  word_t                              mem_load,
	input  lookup_t                            look,
	input  store_cmd_t                         cmd,
	output line_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines,
	output logic [NUM_SETS-1:0]                lru
);

	// Way that a fill lands in
	logic fill_way;

	assign fill_way = lru[addr.idx];

	////////////////////////////////////////////////////////////////////////////
	// Line array and LRU bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lines <= '0;
			lru <= '0;
		end else begin
			case (cmd.op)
				SOP_WRITE_HIT: begin
					// Store word into the hit way
					if (addr.blkoff) begin
						lines[addr.idx][look.hit_way].word1 <= store;
					end else begin
						lines[addr.idx][look.hit_way].word0 <= store;
					end
					lines[addr.idx][look.hit_way].dirty <= 1'b1;
					// Other way becomes LRU
					lru[addr.idx] <= ~look.hit_way;
				end

				SOP_TOUCH: begin
					// Read hit, LRU only
					lru[addr.idx] <= ~look.hit_way;
				end

				SOP_FILL0: begin
					// First fetched word, line not usable until the second
					lines[addr.idx][fill_way].word0 <= mem_load;
					lines[addr.idx][fill_way].valid <= 1'b0;
					lines[addr.idx][fill_way].dirty <= 1'b0;
				end

				SOP_FILL1: begin
					// Second word completes the line
					lines[addr.idx][fill_way].word1 <= mem_load;
					lines[addr.idx][fill_way].tag <= addr.tag;
					lines[addr.idx][fill_way].valid <= 1'b1;
					lines[addr.idx][fill_way].dirty <= 1'b0;
				end

				SOP_CLEAN: begin
					// Flush write-back of the first dirty line is done
					lines[look.dirty_idx][look.dirty_way].dirty <= 1'b0;
				end

				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// A fill replaces a line only while the request still misses both ways
	a_fill_miss: assert property (@(posedge CLK) disable iff (!nRST)
		(cmd.op == SOP_FILL0 || cmd.op == SOP_FILL1) |-> !look.hit);

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
	import dcache_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  proc_req_t req,
	output proc_rsp_t rsp,
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp
);

	// Full array, read by lookup every cycle
	line_t [NUM_SETS-1:0][NUM_WAYS-1:0] lines;
	logic [NUM_SETS-1:0]                lru;
	lookup_t                            look;
	store_cmd_t                         cmd;

	// Tag compare and dirty scan
	dcache_lookup u_lookup (
		.lines  (lines),
		.lru    (lru),
		.addr   (req.addr),
		.result (look)
	);

	// Line registers, written one command per edge
	dcache_set_store u_store (
		.CLK      (CLK),
		.nRST     (nRST),
		.addr     (req.addr),
		.store    (req.store),
		.mem_load (mem_rsp.load),
		.look     (look),
		.cmd      (cmd),
		.lines    (lines),
		.lru      (lru)
	);

	// Miss, write-back and flush FSM
	dcache_ctrl u_ctrl (
		.CLK     (CLK),
		.nRST    (nRST),
		.req     (req),
		.look    (look),
		.mem_rsp (mem_rsp),
		.rsp     (rsp),
		.mem_req (mem_req),
		.cmd     (cmd)
	);

endmodule
